// File: src/epu_pkg.sv
package epu_pkg;

   // Bus and register widths
   localparam int DW = 32;
   localparam int PSR_W = 10;
   localparam int BANK_W = 4;
   localparam int OFF_W = 8;

   // Bank codes, address bits 11..8
   localparam logic [BANK_W-1:0] BANK_PS = 4'd0;
   localparam logic [BANK_W-1:0] BANK_IRQC = 4'd1;
   localparam logic [BANK_W-1:0] BANK_TSC = 4'd2;

   // One-hot offset bit positions, address bits 7..0
   localparam int OFF_PSR = 0;
   localparam int OFF_EPSR = 1;
   localparam int OFF_EPC = 2;
   localparam int OFF_ELSA = 3;
   localparam int OFF_IMR = 0;
   localparam int OFF_IRR = 1;
   localparam int OFF_TSR = 0;
   localparam int OFF_TCR = 1;

   // PSR fields
   localparam int PSR_RM = 4;
   localparam int PSR_IRE = 5;

   // TCR fields
   localparam int TCR_CNT_W = 28;
   localparam int TCR_EN = 28;
   localparam int TCR_IE = 29;

   typedef struct packed {
      logic          syscall;
      logic          eret;
      logic          insn;
      logic          align;
      logic          irq;
      logic [DW-1:0] pc;
      logic [DW-1:0] npc;
      logic [DW-1:0] lsa;
   } exc_commit_t;

   typedef struct packed {
      logic          enter;
      logic          save_epsr;
      logic          eret;
      logic [DW-1:0] epc_nxt;
      logic          elsa_we;
      logic [DW-1:0] elsa_nxt;
   } exc_upd_t;

endpackage

// File: src/msr_if.sv
interface msr_if;

   // One-hot register select inside the bank
   logic [epu_pkg::OFF_W-1:0] off;
   logic                      we;
   logic [epu_pkg::DW-1:0]    wdata;
   // Combinational on off
   logic [epu_pkg::DW-1:0]    rdata;

   modport master (
      output off,
      output we,
      output wdata,
      input  rdata
   );

   modport slave (
      input  off,
      input  we,
      input  wdata,
      output rdata
   );

endinterface

// File: src/msr_apb_decode.sv
module msr_apb_decode (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [epu_pkg::DW-1:0] paddr,
   input  logic [epu_pkg::DW-1:0] pwdata,
   output logic [epu_pkg::DW-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr,
   msr_if.master                  ps_bus,
   msr_if.master                  irqc_bus,
   msr_if.master                  tsc_bus
);

   logic [epu_pkg::BANK_W-1:0] bank;
   logic [epu_pkg::OFF_W-1:0]  off;
   logic [epu_pkg::OFF_W-1:0]  def_off;
   logic                       bank_ps;
   logic                       bank_irqc;
   logic                       bank_tsc;
   logic                       access;
   logic                       err;
   logic                       ok;
   logic [epu_pkg::DW-1:0]     bank_rdata;

   assign bank = paddr[epu_pkg::OFF_W +: epu_pkg::BANK_W];
   assign off = paddr[epu_pkg::OFF_W-1:0];

   assign bank_ps = (bank == epu_pkg::BANK_PS);
   assign bank_irqc = (bank == epu_pkg::BANK_IRQC);
   assign bank_tsc = (bank == epu_pkg::BANK_TSC);

   // Offsets that exist in the selected bank
   always_comb begin
      def_off = '0;
      if (bank_ps) begin
         def_off[epu_pkg::OFF_PSR] = 1'b1;
         def_off[epu_pkg::OFF_EPSR] = 1'b1;
         def_off[epu_pkg::OFF_EPC] = 1'b1;
         def_off[epu_pkg::OFF_ELSA] = 1'b1;
      end
      if (bank_irqc) begin
         def_off[epu_pkg::OFF_IMR] = 1'b1;
         def_off[epu_pkg::OFF_IRR] = 1'b1;
      end
      if (bank_tsc) begin
         def_off[epu_pkg::OFF_TSR] = 1'b1;
         def_off[epu_pkg::OFF_TCR] = 1'b1;
      end
   end

   // Unknown bank, bad offset, or a write to the read-only IRR
   assign err = ~(bank_ps | bank_irqc | bank_tsc) |
                ~$onehot(off) |
                (|(off & ~def_off)) |
                (pwrite & bank_irqc & off[epu_pkg::OFF_IRR]);

   assign access = psel & penable;
   assign ok = access & ~err;

   assign ps_bus.off = off;
   assign ps_bus.wdata = pwdata;
   assign ps_bus.we = ok & pwrite & bank_ps;

   assign irqc_bus.off = off;
   assign irqc_bus.wdata = pwdata;
   assign irqc_bus.we = ok & pwrite & bank_irqc;

   assign tsc_bus.off = off;
   assign tsc_bus.wdata = pwdata;
   assign tsc_bus.we = ok & pwrite & bank_tsc;

   // Read mux
   assign bank_rdata = ({epu_pkg::DW{bank_ps}} & ps_bus.rdata) |
                       ({epu_pkg::DW{bank_irqc}} & irqc_bus.rdata) |
                       ({epu_pkg::DW{bank_tsc}} & tsc_bus.rdata);

   assign prdata = {epu_pkg::DW{ok}} & bank_rdata;
   assign pslverr = access & err;
   // Zero wait states
   assign pready = 1'b1;

endmodule

// File: src/exc_ctrl.sv
module exc_ctrl #(
   parameter logic [epu_pkg::DW-1:0] VEC_SYSCALL = '0,
   parameter logic [epu_pkg::DW-1:0] VEC_INSN = '0,
   parameter logic [epu_pkg::DW-1:0] VEC_ALIGN = '0,
   parameter logic [epu_pkg::DW-1:0] VEC_IRQ = '0
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  epu_pkg::exc_commit_t   commit,
   input  logic [epu_pkg::DW-1:0] epc,
   output epu_pkg::exc_upd_t      upd,
   output logic                   exc_flush,
   output logic [epu_pkg::DW-1:0] exc_flush_tgt
);

   logic enter;
   logic enter_r;

   // Every event except eret enters the handler
   assign enter = commit.syscall | commit.insn | commit.align | commit.irq;

   assign exc_flush = enter | commit.eret;

   assign exc_flush_tgt = ({epu_pkg::DW{commit.syscall}} & VEC_SYSCALL) |
                          ({epu_pkg::DW{commit.insn}} & VEC_INSN) |
                          ({epu_pkg::DW{commit.align}} & VEC_ALIGN) |
                          ({epu_pkg::DW{commit.irq}} & VEC_IRQ) |
                          ({epu_pkg::DW{commit.eret}} & epc);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         enter_r <= 1'b0;
      end else begin
         enter_r <= enter;
      end
   end

   always_comb begin
      upd.enter = enter;
      // Keep the PSR of the first entry when entries come back to back
      upd.save_epsr = enter & ~enter_r;
      upd.eret = commit.eret;
      // Syscall resumes after the trapping instruction
      upd.epc_nxt = commit.syscall ? commit.npc : commit.pc;
      upd.elsa_we = commit.insn | commit.align;
      upd.elsa_nxt = commit.insn ? commit.pc : commit.lsa;
   end

endmodule

// File: src/psr_regs.sv
module psr_regs #(
   parameter logic [epu_pkg::PSR_W-1:0] RST_PSR = '0
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  epu_pkg::exc_upd_t      upd,
   msr_if.slave                   ps_bus,
   output logic                   psr_ire,
   output logic [epu_pkg::DW-1:0] epc
);

   logic [epu_pkg::PSR_W-1:0] psr;
   logic [epu_pkg::PSR_W-1:0] epsr;
   logic [epu_pkg::PSR_W-1:0] psr_ent;
   logic [epu_pkg::DW-1:0]    elsa;
   logic                      wr_psr;
   logic                      wr_epsr;
   logic                      wr_epc;
   logic                      wr_elsa;

   assign wr_psr = ps_bus.we & ps_bus.off[epu_pkg::OFF_PSR];
   assign wr_epsr = ps_bus.we & ps_bus.off[epu_pkg::OFF_EPSR];
   assign wr_epc = ps_bus.we & ps_bus.off[epu_pkg::OFF_EPC];
   assign wr_elsa = ps_bus.we & ps_bus.off[epu_pkg::OFF_ELSA];

   // Handler runs privileged with interrupts off
   always_comb begin
      psr_ent = psr;
      psr_ent[epu_pkg::PSR_RM] = 1'b1;
      psr_ent[epu_pkg::PSR_IRE] = 1'b0;
   end

   // Exception updates take priority over bank writes
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         psr <= RST_PSR;
         epsr <= '0;
         epc <= '0;
         elsa <= '0;
      end else begin
         if (upd.enter) begin
            psr <= psr_ent;
         end else if (upd.eret) begin
            psr <= epsr;
         end else if (wr_psr) begin
            psr <= ps_bus.wdata[epu_pkg::PSR_W-1:0];
         end

         if (upd.enter && upd.save_epsr) begin
            epsr <= psr;
         end else if (wr_epsr) begin
            epsr <= ps_bus.wdata[epu_pkg::PSR_W-1:0];
         end

         if (upd.enter) begin
            epc <= upd.epc_nxt;
         end else if (wr_epc) begin
            epc <= ps_bus.wdata;
         end

         if (upd.elsa_we) begin
            elsa <= upd.elsa_nxt;
         end else if (wr_elsa) begin
            elsa <= ps_bus.wdata;
         end
      end
   end

   assign ps_bus.rdata =
      ({epu_pkg::DW{ps_bus.off[epu_pkg::OFF_PSR]}} &
       {{(epu_pkg::DW-epu_pkg::PSR_W){1'b0}}, psr}) |
      ({epu_pkg::DW{ps_bus.off[epu_pkg::OFF_EPSR]}} &
       {{(epu_pkg::DW-epu_pkg::PSR_W){1'b0}}, epsr}) |
      ({epu_pkg::DW{ps_bus.off[epu_pkg::OFF_EPC]}} & epc) |
      ({epu_pkg::DW{ps_bus.off[epu_pkg::OFF_ELSA]}} & elsa);

   assign psr_ire = psr[epu_pkg::PSR_IRE];

endmodule

// File: src/irqc.sv
module irqc #(
   parameter int NUM_IRQ = 8
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic [NUM_IRQ-1:0] irqs,
   input  logic               tsc_irq,
   input  logic               psr_ire,
   msr_if.slave               irqc_bus,
   output logic               irq_async
);

   logic [epu_pkg::DW-1:0] imr;
   // Bit 0 is the timestamp counter, external lines above it
   logic [NUM_IRQ:0]       irr;
   logic [epu_pkg::DW-1:0] irr_rd;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         imr <= '0;
         irr <= '0;
      end else begin
         irr <= {irqs, tsc_irq};
         if (irqc_bus.we && irqc_bus.off[epu_pkg::OFF_IMR]) begin
            imr <= irqc_bus.wdata;
         end
      end
   end

   assign irr_rd = {{(epu_pkg::DW-NUM_IRQ-1){1'b0}}, irr};

   assign irqc_bus.rdata = ({epu_pkg::DW{irqc_bus.off[epu_pkg::OFF_IMR]}} & imr) |
                           ({epu_pkg::DW{irqc_bus.off[epu_pkg::OFF_IRR]}} & irr_rd);

   // Any unmasked pending request while interrupts are enabled
   assign irq_async = psr_ire & (|(irr & imr[NUM_IRQ:0]));

endmodule

// File: src/tsc.sv
module tsc (
   input  logic clk,
   input  logic rst_n,
   msr_if.slave tsc_bus,
   output logic tsc_irq
);

   logic [epu_pkg::DW-1:0] tsr;
   logic [epu_pkg::DW-1:0] tcr;
   logic                   wr_tsr;
   logic                   wr_tcr;

   assign wr_tsr = tsc_bus.we & tsc_bus.off[epu_pkg::OFF_TSR];
   assign wr_tcr = tsc_bus.we & tsc_bus.off[epu_pkg::OFF_TCR];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tsr <= '0;
         tcr <= '0;
      end else begin
         // A write beats the increment
         if (wr_tsr) begin
            tsr <= tsc_bus.wdata;
         end else if (tcr[epu_pkg::TCR_EN]) begin
            tsr <= tsr + 1;
         end
         if (wr_tcr) begin
            tcr <= tsc_bus.wdata;
         end
      end
   end

   assign tsc_bus.rdata = ({epu_pkg::DW{tsc_bus.off[epu_pkg::OFF_TSR]}} & tsr) |
                          ({epu_pkg::DW{tsc_bus.off[epu_pkg::OFF_TCR]}} & tcr);

   // Compare on the low count bits only
   assign tsc_irq = tcr[epu_pkg::TCR_IE] &
                    (tsr[epu_pkg::TCR_CNT_W-1:0] == tcr[epu_pkg::TCR_CNT_W-1:0]);

endmodule

// File: src/epu_top.sv
module epu_top #(
   parameter int                        NUM_IRQ = 8,
   parameter logic [epu_pkg::DW-1:0]    VEC_SYSCALL = 32'h0000_0100,
   parameter logic [epu_pkg::DW-1:0]    VEC_INSN = 32'h0000_0200,
   parameter logic [epu_pkg::DW-1:0]    VEC_ALIGN = 32'h0000_0300,
   parameter logic [epu_pkg::DW-1:0]    VEC_IRQ = 32'h0000_0400,
   parameter logic [epu_pkg::PSR_W-1:0] RST_PSR = 10'h010
) (
   input  logic                   clk,
   input  logic                   rst_n,
   // APB slave
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [epu_pkg::DW-1:0] paddr,
   input  logic [epu_pkg::DW-1:0] pwdata,
   output logic [epu_pkg::DW-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr,
   // Commit events, at most one per cycle
   input  logic                   commit_syscall,
   input  logic                   commit_eret,
   input  logic                   commit_insn,
   input  logic                   commit_align,
   input  logic                   commit_irq,
   input  logic [epu_pkg::DW-1:0] commit_pc,
   input  logic [epu_pkg::DW-1:0] commit_npc,
   input  logic [epu_pkg::DW-1:0] commit_lsa,
   // Interrupts
   input  logic [NUM_IRQ-1:0]     irqs,
   output logic                   irq_async,
   // Pipeline flush
   output logic                   exc_flush,
   output logic [epu_pkg::DW-1:0] exc_flush_tgt
);

   epu_pkg::exc_commit_t   commit;
   epu_pkg::exc_upd_t      upd;
   logic [epu_pkg::DW-1:0] epc;
   logic                   psr_ire;
   logic                   tsc_irq;

   msr_if ps_bus ();
   msr_if irqc_bus ();
   msr_if tsc_bus ();

   assign commit = '{
      syscall: commit_syscall,
      eret:    commit_eret,
      insn:    commit_insn,
      align:   commit_align,
      irq:     commit_irq,
      pc:      commit_pc,
      npc:     commit_npc,
      lsa:     commit_lsa
   };

   msr_apb_decode u_decode (
      .clk      (clk),
      .rst_n    (rst_n),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .ps_bus   (ps_bus.master),
      .irqc_bus (irqc_bus.master),
      .tsc_bus  (tsc_bus.master)
   );

   exc_ctrl #(
      .VEC_SYSCALL (VEC_SYSCALL),
      .VEC_INSN    (VEC_INSN),
      .VEC_ALIGN   (VEC_ALIGN),
      .VEC_IRQ     (VEC_IRQ)
   ) u_exc_ctrl (
      .clk           (clk),
      .rst_n         (rst_n),
      .commit        (commit),
      .epc           (epc),
      .upd           (upd),
      .exc_flush     (exc_flush),
      .exc_flush_tgt (exc_flush_tgt)
   );

   psr_regs #(
      .RST_PSR (RST_PSR)
   ) u_psr_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .upd     (upd),
      .ps_bus  (ps_bus.slave),
      .psr_ire (psr_ire),
      .epc     (epc)
   );

   irqc #(
      .NUM_IRQ (NUM_IRQ)
   ) u_irqc (
      .clk       (clk),
      .rst_n     (rst_n),
      .irqs      (irqs),
      .tsc_irq   (tsc_irq),
      .psr_ire   (psr_ire),
      .irqc_bus  (irqc_bus.slave),
      .irq_async (irq_async)
   );

   tsc u_tsc (
      .clk     (clk),
      .rst_n   (rst_n),
      .tsc_bus (tsc_bus.slave),
      .tsc_irq (tsc_irq)
   );

endmodule

// File: dv/epu_chk.sv
module epu_chk (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   psel,
   input logic                   penable,
   input logic                   pslverr,
   input logic [epu_pkg::DW-1:0] prdata,
   input logic                   commit_syscall,
   input logic                   commit_eret,
   input logic                   commit_insn,
   input logic                   commit_align,
   input logic                   commit_irq,
   input logic                   psr_ire,
   input logic                   irq_src_any,
   input logic                   irq_async
);

   // At most one committed event per cycle
   a_commit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({commit_syscall, commit_eret, commit_insn, commit_align, commit_irq}))
      else $error("more than one commit flag high in one cycle");

   // Errors only in an access phase after its setup phase and with zero read data
   a_slverr_access: assert property (@(posedge clk) disable iff (!rst_n)
      pslverr |-> (psel && penable && $past(psel && !penable) && prdata == '0))
      else $error("pslverr high outside an APB access phase or with read data");

   // A request needs IRE and a source that IRR sampled at the previous edge
   a_irq_enabled: assert property (@(posedge clk) disable iff (!rst_n)
      irq_async |-> (psr_ire && $past(irq_src_any)))
      else $error("irq_async high without PSR.IRE or without a sampled source");

endmodule

bind epu_top epu_chk u_epu_chk (
   .clk            (clk),
   .rst_n          (rst_n),
   .psel           (psel),
   .penable        (penable),
   .pslverr        (pslverr),
   .prdata         (prdata),
   .commit_syscall (commit_syscall),
   .commit_eret    (commit_eret),
   .commit_insn    (commit_insn),
   .commit_align   (commit_align),
   .commit_irq     (commit_irq),
   .psr_ire        (psr_ire),
   .irq_src_any    (|{irqs, tsc_irq}),
   .irq_async      (irq_async)
);

// File: dv/tb_epu.sv
module tb_epu;

   localparam int NUM_IRQ = 8;
   localparam logic [31:0] V_SYS = 32'h0000_1100;
   localparam logic [31:0] V_INSN = 32'h0000_2200;
   localparam logic [31:0] V_ALIGN = 32'h0000_3300;
   localparam logic [31:0] V_IRQ = 32'h0000_4400;
   localparam logic [9:0] PSR_RST = 10'h010;
   localparam int TMO = 50;

   logic clk = 1'b0;
   logic rst_n, psel, penable, pwrite, pready, pslverr;
   logic [31:0] paddr, pwdata, prdata;
   logic c_sys, c_eret, c_insn, c_align, c_irq;
   logic [31:0] c_pc, c_npc, c_lsa;
   logic [NUM_IRQ-1:0] irqs;
   logic irq_async, exc_flush;
   logic [31:0] exc_flush_tgt;

   int errors = 0;
   int checks = 0;
   int cyc = 0;
   // Reference model of the registers
   logic [9:0] m_psr, m_epsr;
   logic [31:0] m_epc, m_elsa, m_imr, m_tcr;

   epu_top #(
      .NUM_IRQ (NUM_IRQ), .VEC_SYSCALL (V_SYS), .VEC_INSN (V_INSN),
      .VEC_ALIGN (V_ALIGN), .VEC_IRQ (V_IRQ), .RST_PSR (PSR_RST)
   ) uut (
      .clk (clk), .rst_n (rst_n), .psel (psel), .penable (penable), .pwrite (pwrite),
      .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .pready (pready),
      .pslverr (pslverr), .commit_syscall (c_sys), .commit_eret (c_eret),
      .commit_insn (c_insn), .commit_align (c_align), .commit_irq (c_irq),
      .commit_pc (c_pc), .commit_npc (c_npc), .commit_lsa (c_lsa), .irqs (irqs),
      .irq_async (irq_async), .exc_flush (exc_flush), .exc_flush_tgt (exc_flush_tgt)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic timeout(input string what);
      errors++;
      $display("Timeout while waiting for %s", what);
   endtask

   function automatic logic [31:0] msr_addr(input int bank, input int pos);
      return (32'(bank) << 8) | (32'h1 << pos);
   endfunction

   // Setup then access phase, sampled before the closing edge
   task automatic apb(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                      output logic [31:0] rdata, output logic err, output int at);
      int n;
      n = 0;
      psel = 1'b1;
      penable = 1'b0;
      pwrite = wr;
      paddr = addr;
      pwdata = wdata;
      @(posedge clk);
      #1 penable = 1'b1;
      @(negedge clk);
      // No wait states on this port
      check("pready", pready, 1);
      while (!pready) begin
         n++;
         if (n > TMO) begin
            timeout("pready");
            break;
         end
         @(negedge clk);
      end
      rdata = prdata;
      err = pslverr;
      at = cyc;
      @(posedge clk);
      #1 psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic reg_wr(input int bank, input int pos, input logic [31:0] data);
      logic [31:0] rd;
      logic err;
      int at;
      apb(1'b1, msr_addr(bank, pos), data, rd, err, at);
      check("pslverr", err, 0);
   endtask

   task automatic reg_rd(input string name, input int bank, input int pos,
                         input logic [31:0] exp);
      logic [31:0] rd;
      logic err;
      int at;
      apb(1'b0, msr_addr(bank, pos), 0, rd, err, at);
      check("pslverr", err, 0);
      check(name, rd, exp);
   endtask

   task automatic read_all();
      reg_rd("PSR", 0, 0, 32'(m_psr));
      reg_rd("EPSR", 0, 1, 32'(m_epsr));
      reg_rd("EPC", 0, 2, m_epc);
      reg_rd("ELSA", 0, 3, m_elsa);
      reg_rd("IMR", 1, 0, m_imr);
      reg_rd("TCR", 2, 1, m_tcr);
   endtask

   task automatic rand_reg_access();
      int r;
      logic [31:0] v;
      r = $urandom % 6;
      v = $urandom;
      if (r == 5) v[29:28] = 2'b00;
      if ($urandom % 2) begin
         case (r)
            0: m_psr = v[9:0];
            1: m_epsr = v[9:0];
            2: m_epc = v;
            3: m_elsa = v;
            4: m_imr = v;
            default: m_tcr = v;
         endcase
         reg_wr(r < 4 ? 0 : (r == 4 ? 1 : 2), r < 4 ? r : (r == 4 ? 0 : 1), v);
      end else begin
         read_all();
      end
   endtask

   task automatic bad_access();
      int kind;
      int bank;
      logic [7:0] off;
      logic [31:0] rd;
      logic err;
      int at;
      kind = $urandom % 3;
      bank = 3 + ($urandom % 13);
      off = 8'($urandom);
      if (kind == 1) begin
         // Known bank with an offset that is not a defined one-hot bit
         bank = $urandom % 3;
         while ($onehot(off) && off < (bank == 0 ? 8'h10 : 8'h04)) off = 8'($urandom);
      end else if (kind == 2) begin
         bank = 1;
         off = 8'h02;
      end
      apb(kind == 2 ? 1'b1 : 1'($urandom), (32'(bank) << 8) | 32'(off), $urandom, rd, err, at);
      check("pslverr", err, 1);
      check("prdata", rd, 0);
   endtask

   task automatic exception();
      int kind;
      logic [31:0] exp_tgt;
      kind = $urandom % 4;
      c_pc = $urandom;
      c_npc = $urandom;
      c_lsa = $urandom;
      c_sys = (kind == 0);
      c_insn = (kind == 1);
      c_align = (kind == 2);
      c_irq = (kind == 3);
      exp_tgt = kind == 0 ? V_SYS : (kind == 1 ? V_INSN : (kind == 2 ? V_ALIGN : V_IRQ));
      @(negedge clk);
      check("exc_flush", exc_flush, 1);
      check("exc_flush_tgt", exc_flush_tgt, exp_tgt);
      @(posedge clk);
      #1 {c_sys, c_insn, c_align, c_irq} = 4'b0;
      m_epsr = m_psr;
      m_psr[4] = 1'b1;
      m_psr[5] = 1'b0;
      m_epc = (kind == 0) ? c_npc : c_pc;
      if (kind == 1) m_elsa = c_pc;
      if (kind == 2) m_elsa = c_lsa;
      read_all();
   endtask

   task automatic eret();
      m_epsr = 10'($urandom);
      m_epc = $urandom;
      reg_wr(0, 1, 32'(m_epsr));
      reg_wr(0, 2, m_epc);
      c_eret = 1'b1;
      @(negedge clk);
      check("exc_flush", exc_flush, 1);
      check("exc_flush_tgt", exc_flush_tgt, m_epc);
      @(posedge clk);
      #1 c_eret = 1'b0;
      m_psr = m_epsr;
      reg_rd("PSR", 0, 0, 32'(m_psr));
   endtask

   task automatic irq_test();
      logic exp;
      m_imr = $urandom;
      m_psr = 10'($urandom);
      reg_wr(1, 0, m_imr);
      reg_wr(0, 0, 32'(m_psr));
      irqs = NUM_IRQ'($urandom);
      @(posedge clk);
      #1;
      @(negedge clk);
      exp = m_psr[5] & (|({irqs, 1'b0} & m_imr[NUM_IRQ:0]));
      check("irq_async", irq_async, exp);
      @(posedge clk);
      #1 reg_rd("IRR", 1, 1, 32'({irqs, 1'b0}));
   endtask

   task automatic tsc_test();
      logic [31:0] t1, t2, v;
      logic err;
      int a1, a2, n;
      irqs = '0;
      m_tcr = 32'h1000_0000;
      reg_wr(2, 1, m_tcr);
      reg_wr(2, 0, $urandom & 32'h0FFF_FFFF);
      apb(1'b0, msr_addr(2, 0), 0, t1, err, a1);
      repeat (3 + $urandom % 10) @(posedge clk);
      #1 apb(1'b0, msr_addr(2, 0), 0, t2, err, a2);
      check("TSR delta", t2 - t1, 32'(a2 - a1));
      // Compare a few counts ahead with interrupts routed through
      m_imr = 32'h1;
      m_psr[5] = 1'b1;
      reg_wr(1, 0, m_imr);
      reg_wr(0, 0, 32'(m_psr));
      apb(1'b0, msr_addr(2, 0), 0, t1, err, a1);
      v = (t1 + 12) & 32'h0FFF_FFFF;
      m_tcr = 32'h3000_0000 | v;
      reg_wr(2, 1, m_tcr);
      n = 0;
      @(negedge clk);
      while (!irq_async) begin
         n++;
         if (n > TMO) begin
            timeout("irq_async from the timestamp compare");
            break;
         end
         @(negedge clk);
      end
      // TSR is t1+3 here, reaches the compare in 9 edges and IRR takes it one edge later
      check("irq_async cycles after TCR write", n, 10);
      @(posedge clk);
      // Stop the counter on the compare value so IRR bit 0 stays set
      m_tcr = 32'h2000_0000 | v;
      #1 reg_wr(2, 1, m_tcr);
      reg_wr(2, 0, v);
      reg_rd("IRR", 1, 1, 32'h1);
   endtask

   initial begin
      void'($urandom(63));
      rst_n = 1'b0;
      {psel, penable, pwrite} = 3'b0;
      paddr = '0;
      pwdata = '0;
      {c_sys, c_eret, c_insn, c_align, c_irq} = 5'b0;
      c_pc = '0;
      c_npc = '0;
      c_lsa = '0;
      irqs = '0;
      m_psr = PSR_RST;
      {m_epsr, m_epc, m_elsa, m_imr, m_tcr} = '0;
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;
      check("exc_flush", exc_flush, 0);
      check("irq_async", irq_async, 0);
      check("pslverr", pslverr, 0);
      read_all();
      repeat (60) rand_reg_access();
      repeat (20) begin
         bad_access();
         read_all();
      end
      repeat (12) exception();
      repeat (6) eret();
      repeat (10) irq_test();
      tsc_test();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: list.f
src/epu_pkg.sv
src/msr_if.sv
src/msr_apb_decode.sv
src/exc_ctrl.sv
src/psr_regs.sv
src/irqc.sv
src/tsc.sv
src/epu_top.sv
dv/epu_chk.sv
dv/tb_epu.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log for the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module tb_epu -f list.f \
   > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_epu > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log

grep -q "TB FAILED" sim.log && { echo "Fail message found in sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "No pass message in sim.log"; exit 1; }
exit 0
